// File: Makefile
TOP = tb_mul_unit

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "=== PASS ===" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/mul_cfg_pkg.sv
// Multiplier configuration.
// Mode codes, pipeline latency and SIMD lane counts.

package mul_cfg_pkg;

    // Operating mode as presented at the top level.
    typedef logic [1:0] mul_mode_t;

    localparam mul_mode_t MODE_SCALAR = 2'd0;
    localparam mul_mode_t MODE_SIMD16 = 2'd1;
    localparam mul_mode_t MODE_SIMD8  = 2'd2;

    // Rising edges from the edge that samples start to finished.
    localparam int MUL_LATENCY = 2;

    // Independent products per mode.
    localparam int SIMD16_LANES = 4;
    localparam int SIMD8_LANES  = 16;

endpackage

// File: common/mul_types_pkg.sv
// Multiplier data types.
// Operand lanes, product widths and the signedness pair used by every
// level of the Vedic multiplier tree.

package mul_types_pkg;

    // Operand lanes.
    typedef logic [7:0]  op8_t;
    typedef logic [15:0] op16_t;
    typedef logic [31:0] op32_t;

    // Products of two equal-width lanes.
    typedef logic [15:0] prod16_t;
    typedef logic [31:0] prod32_t;
    typedef logic [63:0] prod64_t;

    // Signedness pair of one multiplication.
    // Bit 0 marks the multiplier as signed, bit 1 the multiplicand.
    typedef logic [1:0]  sign_sel_t;

endpackage

// File: sources.f
common/mul_types_pkg.sv
common/mul_cfg_pkg.sv
vedic/vedic_mul8.sv
vedic/vedic_mul16.sv
vedic/vedic_mul32.sv
src/mul_unit.sv
test/tb_mul_unit.sv

// File: src/mul_unit.sv
// Pipelined Vedic multiplier unit.
// Decodes the mode code and drives the 32x32 multiplier tree, which
// returns a scalar, SIMD16 or SIMD8 result two cycles after start.

`timescale 1ns/1ps

module mul_unit (
    input  logic                                   CLK,
    input  logic                                   reset,
    input  logic                                   start,
    input  mul_cfg_pkg::mul_mode_t                 mode,
    input  mul_types_pkg::op32_t                   multiplicand,
    input  mul_types_pkg::op32_t                   multiplier,
    input  mul_types_pkg::op16_t                   simd_multiplicand3,
    input  mul_types_pkg::op16_t                   simd_multiplier3,
    input  mul_types_pkg::op16_t                   simd_multiplicand4,
    input  mul_types_pkg::op16_t                   simd_multiplier4,
    input  logic [127:0]                           simd_8_bit_operands,
    input  mul_types_pkg::sign_sel_t               is_signed,
    input  logic [mul_cfg_pkg::SIMD8_LANES*2-1:0]  simd_signed,
    output logic                                   finished,
    output mul_types_pkg::prod64_t                 product,
    output mul_types_pkg::prod32_t                 simd_product3,
    output mul_types_pkg::prod32_t                 simd_product4,
    output logic [127:0]                           simd_product_8_bits
);

    logic is_simd_8;
    logic is_simd_16;

    // Unknown codes fall back to scalar.
    always_comb begin
        is_simd_8  = 1'b0;
        is_simd_16 = 1'b0;
        case (mode)
            mul_cfg_pkg::MODE_SIMD16: is_simd_16 = 1'b1;
            mul_cfg_pkg::MODE_SIMD8:  is_simd_8  = 1'b1;
            mul_cfg_pkg::MODE_SCALAR: ;
            default: ;
        endcase
    end

    vedic_mul32 u_mul32 (
        .CLK                 (CLK),
        .reset               (reset),
        .multiplicand        (multiplicand),
        .multiplier          (multiplier),
        .simd_multiplicand3  (simd_multiplicand3),
        .simd_multiplier3    (simd_multiplier3),
        .simd_multiplicand4  (simd_multiplicand4),
        .simd_multiplier4    (simd_multiplier4),
        .simd_8_bit_operands (simd_8_bit_operands),
        .is_signed           (is_signed),
        .start               (start),
        .is_simd_8           (is_simd_8),
        .is_simd_16          (is_simd_16),
        .simd_signed         (simd_signed),
        .finished            (finished),
        .product             (product),
        .simd_product3       (simd_product3),
        .simd_product4       (simd_product4),
        .simd_product_8_bits (simd_product_8_bits)
    );

    a_mode_known: assert property (@(posedge CLK) disable iff (reset)
        start |-> !$isunknown(mode));

endmodule

// File: test/tb_mul_unit.sv
// Testbench for the pipelined Vedic multiplier unit.
// Directed checks of reset, scalar, SIMD16 and SIMD8 products and back-to-back issue.

`timescale 1ns/1ps

module tb_mul_unit;

    localparam int LATENCY = 2;
    localparam int TIMEOUT = 10;

    logic                          CLK;
    logic                          reset;
    logic                          start;
    mul_cfg_pkg::mul_mode_t        mode;
    mul_types_pkg::op32_t          multiplicand;
    mul_types_pkg::op32_t          multiplier;
    mul_types_pkg::op16_t          simd_multiplicand3;
    mul_types_pkg::op16_t          simd_multiplier3;
    mul_types_pkg::op16_t          simd_multiplicand4;
    mul_types_pkg::op16_t          simd_multiplier4;
    logic [127:0]                  simd_8_bit_operands;
    mul_types_pkg::sign_sel_t      is_signed;
    logic [31:0]                   simd_signed;
    logic                          finished;
    mul_types_pkg::prod64_t        product;
    mul_types_pkg::prod32_t        simd_product3;
    mul_types_pkg::prod32_t        simd_product4;
    logic [127:0]                  simd_product_8_bits;

    int mismatch_count = 0;
    int timeout_count  = 0;
    int cycle_count    = 0;

    // Expected results in issue order.
    logic [63:0]            prod_q [$];
    logic [31:0]            p3_q [$];
    logic [31:0]            p4_q [$];
    logic [127:0]           p8_q [$];
    mul_cfg_pkg::mul_mode_t mode_q [$];
    int                     cycle_q [$];

    mul_unit DUT (
        .CLK                 (CLK),
        .reset               (reset),
        .start               (start),
        .mode                (mode),
        .multiplicand        (multiplicand),
        .multiplier          (multiplier),
        .simd_multiplicand3  (simd_multiplicand3),
        .simd_multiplier3    (simd_multiplier3),
        .simd_multiplicand4  (simd_multiplicand4),
        .simd_multiplier4    (simd_multiplier4),
        .simd_8_bit_operands (simd_8_bit_operands),
        .is_signed           (is_signed),
        .simd_signed         (simd_signed),
        .finished            (finished),
        .product             (product),
        .simd_product3       (simd_product3),
        .simd_product4       (simd_product4),
        .simd_product_8_bits (simd_product_8_bits)
    );

    always #10 CLK = ~CLK;

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
    end

    // Sign or zero extends both operands of the given width and multiplies them.
    function automatic logic [63:0] wide_product(input logic [31:0] a, input logic [31:0] b,
                                                 input int width, input logic [1:0] sgn);
        logic [63:0] mask;
        logic [63:0] ea;
        logic [63:0] eb;
        mask = (64'd1 << width) - 64'd1;
        ea = {32'b0, a} & mask;
        eb = {32'b0, b} & mask;
        if (sgn[1] && a[width-1]) ea = ea | ~mask;
        if (sgn[0] && b[width-1]) eb = eb | ~mask;
        return ea * eb;
    endfunction

    function automatic logic [31:0] lane16_product(input logic [15:0] a, input logic [15:0] b,
                                                   input logic [1:0] sgn);
        logic [63:0] t;
        t = wide_product({16'b0, a}, {16'b0, b}, 16, sgn);
        return t[31:0];
    endfunction

    function automatic logic [15:0] lane8_product(input logic [7:0] a, input logic [7:0] b,
                                                  input logic [1:0] sgn);
        logic [63:0] t;
        t = wide_product({24'b0, a}, {24'b0, b}, 8, sgn);
        return t[15:0];
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    task automatic finish_run();
        $display("Errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic randomize_operands();
        multiplicand        = $urandom;
        multiplier          = $urandom;
        simd_multiplicand3  = $urandom;
        simd_multiplier3    = $urandom;
        simd_multiplicand4  = $urandom;
        simd_multiplier4    = $urandom;
        simd_8_bit_operands = {$urandom, $urandom, $urandom, $urandom};
        is_signed           = $urandom;
        simd_signed         = $urandom;
    endtask

    // Computes the expected outputs from the inputs currently driven.
    task automatic push_expected();
        logic [63:0]  e_prod;
        logic [31:0]  e_p3;
        logic [31:0]  e_p4;
        logic [127:0] e_p8;
        logic [15:0]  x;
        logic [15:0]  y;
        logic [31:0]  pp;
        e_prod = '0;
        e_p3   = '0;
        e_p4   = '0;
        e_p8   = '0;
        if (mode == mul_cfg_pkg::MODE_SIMD16) begin
            e_prod[31:0]  = lane16_product(multiplicand[31:16], multiplicand[15:0],
                                           simd_signed[1:0]);
            e_prod[63:32] = lane16_product(multiplier[31:16], multiplier[15:0], simd_signed[3:2]);
            e_p3 = lane16_product(simd_multiplicand3, simd_multiplier3, simd_signed[5:4]);
            e_p4 = lane16_product(simd_multiplicand4, simd_multiplier4, simd_signed[7:6]);
        end else if (mode == mul_cfg_pkg::MODE_SIMD8) begin
            for (int i = 0; i < 4; i++) begin
                x = (i == 0) ? multiplicand[31:16] : (i == 1) ? multiplier[31:16] :
                    (i == 2) ? simd_multiplicand3 : simd_multiplicand4;
                y = (i == 0) ? multiplicand[15:0] : (i == 1) ? multiplier[15:0] :
                    (i == 2) ? simd_multiplier3 : simd_multiplier4;
                pp = {lane8_product(y[15:8], y[7:0], simd_signed[8*i+2 +: 2]),
                      lane8_product(x[15:8], x[7:0], simd_signed[8*i +: 2])};
                e_p8[32*i +: 16] = lane8_product(simd_8_bit_operands[32*i +: 8],
                                                 simd_8_bit_operands[32*i+8 +: 8],
                                                 simd_signed[8*i+4 +: 2]);
                e_p8[32*i+16 +: 16] = lane8_product(simd_8_bit_operands[32*i+16 +: 8],
                                                    simd_8_bit_operands[32*i+24 +: 8],
                                                    simd_signed[8*i+6 +: 2]);
                case (i)
                    0: e_prod[31:0]  = pp;
                    1: e_prod[63:32] = pp;
                    2: e_p3          = pp;
                    default: e_p4    = pp;
                endcase
            end
        end else begin
            e_prod = wide_product(multiplicand, multiplier, 32, is_signed);
        end
        prod_q.push_back(e_prod);
        p3_q.push_back(e_p3);
        p4_q.push_back(e_p4);
        p8_q.push_back(e_p8);
        mode_q.push_back(mode);
        cycle_q.push_back(cycle_count);
    endtask

    // Holds start for the current cycle; the caller drops it when the burst ends.
    task automatic issue_op();
        start = 1'b1;
        push_expected();
        @(negedge CLK);
    endtask

    task automatic collect_results(input int count);
        int                     waited;
        int                     issued_at;
        mul_cfg_pkg::mul_mode_t op_mode;
        for (int n = 0; n < count; n++) begin
            waited = 0;
            @(negedge CLK);
            while (finished !== 1'b1 && waited < TIMEOUT) begin
                @(negedge CLK);
                waited++;
            end
            if (finished !== 1'b1) begin
                $display("Timeout at %0t: finished never came for operation %0d", $time, n);
                timeout_count++;
                finish_run();
            end else begin
                issued_at = cycle_q.pop_front();
                op_mode   = mode_q.pop_front();
                check_value("finished cycle", issued_at + LATENCY, cycle_count);
                check_value("product", prod_q.pop_front(), product);
                if (op_mode != mul_cfg_pkg::MODE_SCALAR) begin
                    check_value("simd_product3", p3_q.pop_front(), simd_product3);
                    check_value("simd_product4", p4_q.pop_front(), simd_product4);
                end else begin
                    void'(p3_q.pop_front());
                    void'(p4_q.pop_front());
                end
                if (op_mode == mul_cfg_pkg::MODE_SIMD8) begin
                    check_value("simd_product_8_bits", p8_q.pop_front(), simd_product_8_bits);
                end else begin
                    void'(p8_q.pop_front());
                end
            end
        end
    endtask

    task automatic run_single();
        issue_op();
        start = 1'b0;
        collect_results(1);
    endtask

    task automatic check_reset_state();
        for (int i = 0; i < 14; i++) begin
            @(negedge CLK);
            if (i == 9) reset = 1'b0;
            check_value("finished", 1'b0, finished);
            check_value("product", 64'd0, product);
        end
    endtask

    task automatic check_scalar();
        logic [31:0] corners [4];
        corners = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};
        mode = mul_cfg_pkg::MODE_SCALAR;
        for (int s = 0; s < 4; s++) begin
            is_signed = s[1:0];
            for (int i = 0; i < 4; i++) begin
                for (int j = 0; j < 4; j++) begin
                    multiplicand = corners[i];
                    multiplier   = corners[j];
                    run_single();
                end
            end
        end
        for (int n = 0; n < 20; n++) begin
            randomize_operands();
            for (int s = 0; s < 4; s++) begin
                is_signed = s[1:0];
                run_single();
            end
        end
    endtask

    task automatic check_simd(input mul_cfg_pkg::mul_mode_t simd_mode);
        for (int n = 0; n < 20; n++) begin
            randomize_operands();
            mode = simd_mode;
            run_single();
        end
    endtask

    // Eight starts on consecutive cycles, cycling through the three modes.
    task automatic check_back_to_back();
        mul_cfg_pkg::mul_mode_t mix [3];
        mix = '{mul_cfg_pkg::MODE_SCALAR, mul_cfg_pkg::MODE_SIMD16, mul_cfg_pkg::MODE_SIMD8};
        fork
            begin
                for (int i = 0; i < 8; i++) begin
                    randomize_operands();
                    mode = mix[i % 3];
                    issue_op();
                end
                start = 1'b0;
            end
            collect_results(8);
        join
    endtask

    initial begin
        void'($urandom(32'hdf02_6b7a));
        CLK                 = 1'b0;
        reset               = 1'b1;
        start               = 1'b0;
        mode                = mul_cfg_pkg::MODE_SCALAR;
        multiplicand        = '0;
        multiplier          = '0;
        simd_multiplicand3  = '0;
        simd_multiplier3    = '0;
        simd_multiplicand4  = '0;
        simd_multiplier4    = '0;
        simd_8_bit_operands = '0;
        is_signed           = '0;
        simd_signed         = '0;
        check_reset_state();
        check_scalar();
        check_simd(mul_cfg_pkg::MODE_SIMD16);
        check_simd(mul_cfg_pkg::MODE_SIMD8);
        check_back_to_back();
        finish_run();
    end

endmodule

// File: vedic/vedic_mul16.sv
// Two-stage 16x16 multiplier built from four 8x8 Vedic cores.
// Normal mode combines the byte cross-products into one 32-bit product.
// SIMD mode runs four independent 8x8 lanes on the same cores.

`timescale 1ns/1ps

module vedic_mul16 (
    input  logic                      CLK,
    input  logic                      reset,
    input  mul_types_pkg::op16_t      multiplicand,
    input  mul_types_pkg::op16_t      multiplier,
    input  mul_types_pkg::op8_t       simd_multiplicand3,
    input  mul_types_pkg::op8_t       simd_multiplier3,
    input  mul_types_pkg::op8_t       simd_multiplicand4,
    input  mul_types_pkg::op8_t       simd_multiplier4,
    input  mul_types_pkg::sign_sel_t  is_signed,
    input  logic                      start,
    input  logic                      is_simd,
    input  logic [7:0]                simd_signed,
    output logic                      finished,
    output mul_types_pkg::prod32_t    product,
    output mul_types_pkg::prod16_t    simd_product3,
    output mul_types_pkg::prod16_t    simd_product4
);

    mul_types_pkg::op8_t      core_a [4];
    mul_types_pkg::op8_t      core_b [4];
    mul_types_pkg::sign_sel_t core_sgn [4];
    mul_types_pkg::prod16_t   core_p [4];
    mul_types_pkg::prod16_t   core_q [4];
    mul_types_pkg::sign_sel_t sgn_q;
    mul_types_pkg::prod32_t   sum;
    logic                     simd_q;
    logic                     valid_q;
    logic                     ext_hl;
    logic                     ext_lh;

    // In SIMD mode lane 0 is the upper byte of multiplicand times its lower
    // byte, and lane 1 is the same for multiplier.
    always_comb begin
        core_a[0] = multiplicand[15:8];
        if (is_simd) begin
            core_b[0]   = multiplicand[7:0];
            core_sgn[0] = simd_signed[1:0];
            core_a[1]   = multiplier[15:8];
            core_b[1]   = multiplier[7:0];
            core_sgn[1] = simd_signed[3:2];
            core_a[2]   = simd_multiplicand3;
            core_b[2]   = simd_multiplier3;
            core_sgn[2] = simd_signed[5:4];
            core_a[3]   = simd_multiplicand4;
            core_b[3]   = simd_multiplier4;
            core_sgn[3] = simd_signed[7:6];
        end else begin
            core_b[0]   = multiplier[15:8];
            core_sgn[0] = is_signed;
            core_a[1]   = multiplicand[15:8];
            core_b[1]   = multiplier[7:0];
            core_sgn[1] = {is_signed[1], 1'b0};
            core_a[2]   = multiplicand[7:0];
            core_b[2]   = multiplier[15:8];
            core_sgn[2] = {1'b0, is_signed[0]};
            core_a[3]   = multiplicand[7:0];
            core_b[3]   = multiplier[7:0];
            core_sgn[3] = 2'b00;
        end
    end

    for (genvar i = 0; i < 4; i++) begin : g_core
        vedic_mul8 u_mul8 (
            .a         (core_a[i]),
            .b         (core_b[i]),
            .is_signed (core_sgn[i]),
            .p         (core_p[i])
        );
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            for (int k = 0; k < 4; k++) begin
                core_q[k] <= core_p[k];
            end
            sgn_q  <= is_signed;
            simd_q <= is_simd;
        end
    end

    // Only the mixed cross-products carry sign into the upper byte.
    assign ext_hl = sgn_q[1] & core_q[1][15];
    assign ext_lh = sgn_q[0] & core_q[2][15];
    assign sum    = {core_q[0], 16'b0}
                  + {{8{ext_hl}}, core_q[1], 8'b0}
                  + {{8{ext_lh}}, core_q[2], 8'b0}
                  + {16'b0, core_q[3]};

    always_ff @(posedge CLK) begin
        if (reset) begin
            valid_q       <= 1'b0;
            finished      <= 1'b0;
            product       <= '0;
            simd_product3 <= '0;
            simd_product4 <= '0;
        end else begin
            valid_q  <= start;
            finished <= valid_q;
            if (valid_q) begin
                product       <= simd_q ? {core_q[1], core_q[0]} : sum;
                simd_product3 <= core_q[2];
                simd_product4 <= core_q[3];
            end
        end
    end

    a_latency: assert property (@(posedge CLK) disable iff (reset)
        start |-> ##(mul_cfg_pkg::MUL_LATENCY) finished);

endmodule

// File: vedic/vedic_mul32.sv
// 32x32 Vedic multiplier from four 16x16 units.
// Scalar mode adds the four 16-bit cross-products into a 64-bit product;
// SIMD16 and SIMD8 modes steer independent lanes onto the units and pack
// their results.

`timescale 1ns/1ps

module vedic_mul32 (
    input  logic                                   CLK,
    input  logic                                   reset,
    input  mul_types_pkg::op32_t                   multiplicand,
    input  mul_types_pkg::op32_t                   multiplier,
    input  mul_types_pkg::op16_t                   simd_multiplicand3,
    input  mul_types_pkg::op16_t                   simd_multiplier3,
    input  mul_types_pkg::op16_t                   simd_multiplicand4,
    input  mul_types_pkg::op16_t                   simd_multiplier4,
    input  logic [127:0]                           simd_8_bit_operands,
    input  mul_types_pkg::sign_sel_t               is_signed,
    input  logic                                   start,
    input  logic                                   is_simd_8,
    input  logic                                   is_simd_16,
    input  logic [mul_cfg_pkg::SIMD8_LANES*2-1:0]  simd_signed,
    output logic                                   finished,
    output mul_types_pkg::prod64_t                 product,
    output mul_types_pkg::prod32_t                 simd_product3,
    output mul_types_pkg::prod32_t                 simd_product4,
    output logic [127:0]                           simd_product_8_bits
);

    localparam int UNITS = mul_cfg_pkg::SIMD16_LANES;

    mul_types_pkg::op16_t      mcands [UNITS];
    mul_types_pkg::op16_t      mpliers [UNITS];
    mul_types_pkg::sign_sel_t  unit_sgn [UNITS];
    mul_types_pkg::prod32_t    pp [UNITS];
    mul_types_pkg::prod16_t    lane3 [UNITS];
    mul_types_pkg::prod16_t    lane4 [UNITS];
    logic [UNITS-1:0]          unit_finished;
    mul_types_pkg::sign_sel_t  sgn_q1;
    mul_types_pkg::sign_sel_t  sgn_q2;
    mul_types_pkg::prod64_t    sum;
    logic                      is_simd;
    logic                      simd_q1;
    logic                      simd_q2;
    logic                      valid_q;
    logic                      ext1;
    logic                      ext2;

    assign is_simd = is_simd_8 | is_simd_16;

    always_comb begin
        for (int k = 0; k < UNITS; k++) begin
            unit_sgn[k] = 2'b00;
        end
        mcands[0] = multiplicand[31:16];
        if (is_simd) begin
            mpliers[0] = multiplicand[15:0];
            mcands[1]  = multiplier[31:16];
            mpliers[1] = multiplier[15:0];
            mcands[2]  = simd_multiplicand3;
            mpliers[2] = simd_multiplier3;
            mcands[3]  = simd_multiplicand4;
            mpliers[3] = simd_multiplier4;
            if (is_simd_16) begin
                for (int k = 0; k < UNITS; k++) begin
                    unit_sgn[k] = simd_signed[2*k +: 2];
                end
            end
        end else begin
            mpliers[0]  = multiplier[31:16];
            mcands[1]   = multiplicand[31:16];
            mpliers[1]  = multiplier[15:0];
            mcands[2]   = multiplicand[15:0];
            mpliers[2]  = multiplier[31:16];
            mcands[3]   = multiplicand[15:0];
            mpliers[3]  = multiplier[15:0];
            // Only the high halves carry sign.
            unit_sgn[0] = is_signed;
            unit_sgn[1] = {is_signed[1], 1'b0};
            unit_sgn[2] = {1'b0, is_signed[0]};
        end
    end

    for (genvar i = 0; i < UNITS; i++) begin : g_unit
        vedic_mul16 u_mul16 (
            .CLK                (CLK),
            .reset              (reset),
            .multiplicand       (mcands[i]),
            .multiplier         (mpliers[i]),
            .simd_multiplicand3 (simd_8_bit_operands[32*i +: 8]),
            .simd_multiplier3   (simd_8_bit_operands[32*i+8 +: 8]),
            .simd_multiplicand4 (simd_8_bit_operands[32*i+16 +: 8]),
            .simd_multiplier4   (simd_8_bit_operands[32*i+24 +: 8]),
            .is_signed          (unit_sgn[i]),
            .start              (start),
            .is_simd            (is_simd_8),
            .simd_signed        (simd_signed[8*i +: 8]),
            .finished           (unit_finished[i]),
            .product            (pp[i]),
            .simd_product3      (lane3[i]),
            .simd_product4      (lane4[i])
        );
    end

    // The combining mode travels beside the units and is written with each result.
    always_ff @(posedge CLK) begin
        if (start) begin
            simd_q1 <= is_simd;
            sgn_q1  <= is_signed;
        end
    end

    always_ff @(posedge CLK) begin
        if (reset) begin
            valid_q <= 1'b0;
            simd_q2 <= 1'b0;
            sgn_q2  <= 2'b00;
        end else begin
            valid_q <= start;
            if (valid_q) begin
                simd_q2 <= simd_q1;
                sgn_q2  <= sgn_q1;
            end
        end
    end

    assign ext1 = sgn_q2[1] & pp[1][31];
    assign ext2 = sgn_q2[0] & pp[2][31];
    assign sum  = {pp[0], 32'b0}
                + {{16{ext1}}, pp[1], 16'b0}
                + {{16{ext2}}, pp[2], 16'b0}
                + {32'b0, pp[3]};

    assign finished      = &unit_finished;
    assign product       = simd_q2 ? {pp[1], pp[0]} : sum;
    assign simd_product3 = pp[2];
    assign simd_product4 = pp[3];

    always_comb begin
        for (int k = 0; k < UNITS; k++) begin
            simd_product_8_bits[32*k +: 16]    = lane3[k];
            simd_product_8_bits[32*k+16 +: 16] = lane4[k];
        end
    end

    a_mode_onehot: assert property (@(posedge CLK) disable iff (reset)
        !(is_simd_8 && is_simd_16));

endmodule

// File: vedic/vedic_mul8.sv
// Combinational 8x8 Vedic multiplier core.
// Urdhva-Tiryagbhyam column sums with sign correction of the top row and
// column, so every signed/unsigned operand combination uses the same core.

`timescale 1ns/1ps

module vedic_mul8 (
    input  mul_types_pkg::op8_t      a,
    input  mul_types_pkg::op8_t      b,
    input  mul_types_pkg::sign_sel_t is_signed,
    output mul_types_pkg::prod16_t   p
);

    // Column k collects every crosswise bit product with i + j == k.
    logic signed [4:0]  col [15];
    logic signed [15:0] term;
    logic [15:0]        acc;

    always_comb begin
        for (int k = 0; k < 15; k++) begin
            col[k] = '0;
        end
        for (int i = 0; i < 8; i++) begin
            for (int j = 0; j < 8; j++) begin
                if (a[i] && b[j]) begin
                    // The top bit of a signed operand weighs -2^7.
                    if ((is_signed[1] && i == 7) != (is_signed[0] && j == 7)) begin
                        col[i + j] = col[i + j] - 5'sd1;
                    end else begin
                        col[i + j] = col[i + j] + 5'sd1;
                    end
                end
            end
        end
    end

    // Carry the column sums into the final product.
    always_comb begin
        acc  = '0;
        term = '0;
        for (int k = 0; k < 15; k++) begin
            term = col[k];
            acc  = acc + (term <<< k);
        end
    end

    assign p = acc;

endmodule
